//--- files.f
common/ssync_pkg.sv
ssync_corr/sample_window.sv
ssync_corr/preamble_correlator.sv
ssync_peak/peak_detector.sv
verilog/result_handshake.sv
verilog/ssync_top.sv
dv/tb_clock.sv
dv/ssync_checker.sv
dv/ssync_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ssync_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "test passed" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/ssync_tb.sv
module ssync_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_LEN = 256;
    localparam int GUARD     = 5;
    localparam int LEN       = ssync_pkg::PREAMBLE_LEN;
    localparam int AMP       = 200;         // preamble amplitude against +-3 noise
    localparam int TIMEOUT   = 2000;        // cycles allowed per wait

    logic               clk;
    logic               rst_pwr;
    logic               test_rst;
    logic               rst;
    ssync_pkg::sample_t di_re;
    ssync_pkg::sample_t di_im;
    logic               di_vld;
    ssync_pkg::sample_t do_re;
    ssync_pkg::sample_t do_im;
    logic               do_vld;
    logic               res_req;
    ssync_pkg::idx_t    res_indx;
    logic               res_ack;

    int seed;
    int frame_re [FRAME_LEN];
    int frame_im [FRAME_LEN];
    int n_run;
    int n_ok;
    int n_bad;
    int errors;                             // failures in the running test

    assign rst = rst_pwr | test_rst;

    tb_clock u_clock (.clk(clk), .rst(rst_pwr));

    ssync_top #(.FRAME_LEN(FRAME_LEN), .GUARD(GUARD)) DUT (
        .clk(clk), .rst(rst),
        .di_re(di_re), .di_im(di_im), .di_vld(di_vld),
        .do_re(do_re), .do_im(do_im), .do_vld(do_vld),
        .res_req(res_req), .res_indx(res_indx), .res_ack(res_ack)
    );

    function automatic int tap(input int k);
        return ssync_pkg::PREAMBLE_TAPS[k] ? 1 : -1;
    endfunction

    // small noise with the scaled preamble starting at offset
    task automatic build_frame(input int offset);
        for (int n = 0; n < FRAME_LEN; n++) begin
            frame_re[n] = $random(seed) % 4;
            frame_im[n] = $random(seed) % 4;
            if (n >= offset && n < offset + LEN) begin
                frame_re[n] += AMP * tap(n - offset);
                frame_im[n] -= (AMP / 2) * tap(n - offset);
            end
        end
    endtask

    // strict max of |re| + |im| over all windows, moved back by GUARD
    function automatic ssync_pkg::idx_t expected_index();
        int              best;
        int              c_re;
        int              c_im;
        int              energy;
        ssync_pkg::idx_t idx;
        best = 0;
        idx  = '0;
        for (int i = 0; i <= FRAME_LEN - LEN; i++) begin
            c_re = 0;
            c_im = 0;
            for (int k = 0; k < LEN; k++) begin
                c_re += tap(k) * frame_re[i + k];
                c_im += tap(k) * frame_im[i + k];
            end
            energy = (c_re < 0 ? -c_re : c_re) + (c_im < 0 ? -c_im : c_im);
            if (energy > best) begin
                best = energy;
                idx  = ssync_pkg::idx_t'(i - GUARD);   // wraps mod 1024
            end
        end
        return idx;
    endfunction

    task automatic drive(input int re, input int im, input logic vld);
        @(negedge clk);
        di_re  = ssync_pkg::sample_t'(re);
        di_im  = ssync_pkg::sample_t'(im);
        di_vld = vld;
    endtask

    task automatic reset_dut();
        @(negedge clk);
        di_vld   = 1'b0;
        res_ack  = 1'b0;
        test_rst = 1'b1;
        repeat (2) @(negedge clk);
        test_rst = 1'b0;
    endtask

    //----------------------------------------------------------------------
    // drives one frame, takes the result and keeps driving past it
    //----------------------------------------------------------------------
    task automatic run_test(input string name, input int offset, input bit gaps);
        ssync_pkg::idx_t exp_idx;
        int              cycles;
        bit              again;
        exp_idx = expected_index();
        errors  = 0;
        again   = 1'b0;
        reset_dut();
        for (int n = 0; n < FRAME_LEN + 8; n++) begin   // 8 samples past the frame
            if (gaps) repeat ({$random(seed)} % 3) drive($random(seed) % 900, 0, 1'b0);
            if (n < FRAME_LEN) drive(frame_re[n], frame_im[n], 1'b1);
            else drive($random(seed) % 900, $random(seed) % 900, 1'b1);
        end
        drive(0, 0, 1'b0);
        cycles = 0;
        while (!res_req && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!res_req) begin
            $display("%s: res_req did not rise within %0d cycles", name, TIMEOUT);
            errors++;
        end else begin
            if (res_indx !== exp_idx) begin
                $display("CHECK FAILED %s: res_indx expected %0d, actual %0d",
                         name, exp_idx, res_indx);
                errors++;
            end
            repeat ({$random(seed)} % 4) @(negedge clk);   // late ack
            res_ack = 1'b1;
            cycles  = 0;
            while (res_req && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (res_req) begin
                $display("%s: res_req did not fall after res_ack", name);
                errors++;
            end
            res_ack = 1'b0;
        end
        for (int n = 0; n < 40; n++) begin
            drive($random(seed) % 900, $random(seed) % 900, 1'b1);
            if (res_req) again = 1'b1;
        end
        drive(0, 0, 1'b0);
        if (again) begin
            $display("%s: res_req rose again after the frame was done", name);
            errors++;
        end
        n_run++;
        if (errors == 0) n_ok++;
        else n_bad++;
        $display("%-12s offset %0d, index %0d: %s", name, offset, exp_idx,
                 errors == 0 ? "ok" : "FAILED");
    endtask

    initial begin
        int offset;
        int cycles;
        seed     = 17369;
        di_re    = '0;
        di_im    = '0;
        di_vld   = 1'b0;
        res_ack  = 1'b0;
        test_rst = 1'b0;
        n_run    = 0;
        n_ok     = 0;
        n_bad    = 0;
        cycles   = 0;
        while (rst_pwr && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_pwr) begin
            $display("power-on reset still high after %0d cycles", TIMEOUT);
            n_bad++;
        end
        offset = GUARD + {$random(seed)} % (FRAME_LEN - LEN - GUARD);
        build_frame(offset);
        run_test("peak_random", offset, 1'b0);
        run_test("vld_gaps", offset, 1'b1);     // same frame gives the same result
        build_frame(2);
        run_test("guard_wrap", 2, 1'b0);
        build_frame(FRAME_LEN - LEN);
        run_test("peak_last", FRAME_LEN - LEN, 1'b1);
        $display("tests run %0d, ok %0d, failing %0d, assertion errors %0d",
                 n_run, n_ok, n_bad, DUT.u_checker.fail_count);
        if (n_bad == 0 && DUT.u_checker.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // overall limit on the run
    initial begin
        repeat (50000) @(posedge clk);
        $display("simulation did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

//--- dv/ssync_checker.sv
module ssync_checker (
    input logic               clk,
    input logic               rst,
    input ssync_pkg::sample_t di_re,
    input ssync_pkg::sample_t di_im,
    input logic               di_vld,
    input ssync_pkg::sample_t do_re,
    input ssync_pkg::sample_t do_im,
    input logic               do_vld,
    input logic               win_vld,
    input logic               corr_vld,
    input logic               peak_done,
    input logic               res_req,
    input ssync_pkg::idx_t    res_indx,
    input logic               res_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;       // number of failed assertions
    logic past_ok;              // one clock seen since reset
    logic done_seen;            // transfer of this frame finished
    logic peak_seen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            past_ok   <= 1'b0;
            done_seen <= 1'b0;
            peak_seen <= 1'b0;
        end else begin
            past_ok <= 1'b1;
            if (res_req && res_ack) done_seen <= 1'b1;
            if (peak_done) peak_seen <= 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // pass-through and reset state
    //----------------------------------------------------------------------
    a_pass_thru: assert property (@(posedge clk) disable iff (rst)
        past_ok |-> (do_vld == $past(di_vld)) && (do_re == $past(di_re))
                    && (do_im == $past(di_im)))
        else begin
            fail_count = fail_count + 1;
            $error("pass-through mismatch");
        end

    a_reset_low: assert property (@(posedge clk)
        rst |-> !do_vld && !win_vld && !corr_vld && !peak_done && !res_req)
        else begin
            fail_count = fail_count + 1;
            $error("valid high in reset");
        end

    //----------------------------------------------------------------------
    // four-phase result transfer, one per frame
    //----------------------------------------------------------------------
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        res_req && !res_ack |=> res_req && $stable(res_indx))
        else begin
            fail_count = fail_count + 1;
            $error("res_req or res_indx moved");
        end

    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        res_req && res_ack |=> !res_req)
        else begin
            fail_count = fail_count + 1;
            $error("res_req stuck after ack");
        end

    a_one_result: assert property (@(posedge clk) disable iff (rst)
        done_seen |-> !res_req)
        else begin
            fail_count = fail_count + 1;
            $error("second result in frame");
        end

    a_one_peak: assert property (@(posedge clk) disable iff (rst)
        peak_seen |-> !peak_done)
        else begin
            fail_count = fail_count + 1;
            $error("second peak_done in frame");
        end

endmodule

bind ssync_top ssync_checker u_checker (
    .clk(clk), .rst(rst),
    .di_re(di_re), .di_im(di_im), .di_vld(di_vld),
    .do_re(do_re), .do_im(do_im), .do_vld(do_vld),
    .win_vld(win_vld), .corr_vld(corr_vld), .peak_done(peak_done),
    .res_req(res_req), .res_indx(res_indx), .res_ack(res_ack)
);

//--- dv/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // power-on reset, two clock cycles, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- verilog/ssync_top.sv
module ssync_top #(
    parameter int FRAME_LEN = 256,    // samples captured per frame
    parameter int GUARD     = 5       // back-off of the reported index
) (
    input  logic               clk,
    input  logic               rst,
    input  ssync_pkg::sample_t di_re,
    input  ssync_pkg::sample_t di_im,
    input  logic               di_vld,
    output ssync_pkg::sample_t do_re,
    output ssync_pkg::sample_t do_im,
    output logic               do_vld,
    output logic               res_req,
    output ssync_pkg::idx_t    res_indx,
    input  logic               res_ack
);

    ssync_pkg::sample_t win_re;
    ssync_pkg::sample_t win_im;
    logic               win_vld;

    ssync_pkg::corr_t   corr_re;
    ssync_pkg::corr_t   corr_im;
    logic               corr_vld;

    ssync_pkg::idx_t    peak_idx;
    logic               peak_done;

    // pass-through and frame gating
    sample_window #(.FRAME_LEN(FRAME_LEN)) u_window (
        .clk(clk), .rst(rst),
        .di_re(di_re), .di_im(di_im), .di_vld(di_vld),
        .do_re(do_re), .do_im(do_im), .do_vld(do_vld),
        .win_re(win_re), .win_im(win_im), .win_vld(win_vld)
    );

    preamble_correlator u_corr (
        .clk(clk), .rst(rst),
        .win_re(win_re), .win_im(win_im), .win_vld(win_vld),
        .corr_re(corr_re), .corr_im(corr_im), .corr_vld(corr_vld)
    );

    peak_detector #(.FRAME_LEN(FRAME_LEN), .GUARD(GUARD)) u_peak (
        .clk(clk), .rst(rst),
        .corr_re(corr_re), .corr_im(corr_im), .corr_vld(corr_vld),
        .peak_idx(peak_idx), .peak_done(peak_done)
    );

    // one four-phase transfer per frame
    result_handshake u_result (
        .clk(clk), .rst(rst),
        .peak_idx(peak_idx), .peak_done(peak_done),
        .res_req(res_req), .res_indx(res_indx), .res_ack(res_ack)
    );

endmodule

//--- verilog/result_handshake.sv
module result_handshake (
    input  logic            clk,
    input  logic            rst,
    input  ssync_pkg::idx_t peak_idx,
    input  logic            peak_done,
    output logic            res_req,
    output ssync_pkg::idx_t res_indx,
    input  logic            res_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,        // waiting for the frame result
        ST_REQUEST,     // req high, index held
        ST_RELEASE,     // req low, wait for ack to drop
        ST_DONE         // stays here until rst
    } state_t;

    state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:    if (peak_done) state <= ST_REQUEST;
                ST_REQUEST: if (res_ack) state <= ST_RELEASE;
                ST_RELEASE: if (!res_ack) state <= ST_DONE;
                default:    state <= ST_DONE;
            endcase
        end
    end

    // index is captured once, held through the transfer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && peak_done) begin
            res_indx <= peak_idx;
        end
    end

    assign res_req = (state == ST_REQUEST);

endmodule

//--- ssync_peak/peak_detector.sv
module peak_detector #(
    parameter int FRAME_LEN = 256,
    parameter int GUARD     = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  ssync_pkg::corr_t corr_re,
    input  ssync_pkg::corr_t corr_im,
    input  logic             corr_vld,
    output ssync_pkg::idx_t  peak_idx,
    output logic             peak_done
);

    // index of the last correlation value in a frame
    localparam int LAST_IDX = FRAME_LEN - ssync_pkg::PREAMBLE_LEN;

    logic [ssync_pkg::CORR_W-1:0] abs_re;
    logic [ssync_pkg::CORR_W-1:0] abs_im;

    ssync_pkg::idx_t    run_idx;       // index of the next corr value
    ssync_pkg::idx_t    en_idx;
    ssync_pkg::energy_t energy;
    logic               en_vld;
    ssync_pkg::energy_t max_energy;

    // |x| of the most negative value still fits unsigned
    assign abs_re = corr_re[ssync_pkg::CORR_W-1] ? -corr_re : corr_re;
    assign abs_im = corr_im[ssync_pkg::CORR_W-1] ? -corr_im : corr_im;

    //----------------------------------------------------------------------
    // stage 1, L1 energy with its index
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_idx <= '0;
            en_vld  <= 1'b0;
        end else begin
            en_vld <= corr_vld;
            if (corr_vld) run_idx <= run_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (corr_vld) begin
            energy <= ssync_pkg::energy_t'(abs_re) + ssync_pkg::energy_t'(abs_im);
            en_idx <= run_idx;
        end
    end

    //----------------------------------------------------------------------
    // stage 2, strict max search, ties keep the earlier index
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            max_energy <= '0;
            peak_idx   <= '0;
            peak_done  <= 1'b0;
        end else begin
            peak_done <= en_vld && (en_idx == ssync_pkg::idx_t'(LAST_IDX));
            if (en_vld && energy > max_energy) begin
                max_energy <= energy;
                peak_idx   <= ssync_pkg::idx_t'(en_idx - GUARD);  // wraps mod 2^IDX_W
            end
        end
    end

endmodule

//--- ssync_corr/preamble_correlator.sv
module preamble_correlator (
    input  logic               clk,
    input  logic               rst,
    input  ssync_pkg::sample_t win_re,
    input  ssync_pkg::sample_t win_im,
    input  logic               win_vld,
    output ssync_pkg::corr_t   corr_re,
    output ssync_pkg::corr_t   corr_im,
    output logic               corr_vld
);

    localparam int LEN    = ssync_pkg::PREAMBLE_LEN;
    localparam int FILL_W = $clog2(LEN + 1);

    ssync_pkg::sample_t dl_re [LEN];     // index 0 is the oldest sample
    ssync_pkg::sample_t dl_im [LEN];
    ssync_pkg::sample_t nxt_re [LEN];    // window after the pending shift
    ssync_pkg::sample_t nxt_im [LEN];

    logic [FILL_W-1:0] fill_cnt;
    logic              full_next;

    ssync_pkg::corr_t  sum_re;
    ssync_pkg::corr_t  sum_im;

    //----------------------------------------------------------------------
    // window as it looks once the incoming sample is shifted in
    //----------------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < LEN - 1; k++) begin
            nxt_re[k] = dl_re[k + 1];
            nxt_im[k] = dl_im[k + 1];
        end
        nxt_re[LEN-1] = win_re;
        nxt_im[LEN-1] = win_im;
    end

    // +-1 taps, so only adds and subtracts
    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int k = 0; k < LEN; k++) begin
            if (ssync_pkg::PREAMBLE_TAPS[k]) begin
                sum_re = sum_re + ssync_pkg::corr_t'(nxt_re[k]);
                sum_im = sum_im + ssync_pkg::corr_t'(nxt_im[k]);
            end else begin
                sum_re = sum_re - ssync_pkg::corr_t'(nxt_re[k]);
                sum_im = sum_im - ssync_pkg::corr_t'(nxt_im[k]);
            end
        end
    end

    assign full_next = (fill_cnt >= FILL_W'(LEN - 1));  // this shift fills it

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_cnt <= '0;
            corr_vld <= 1'b0;
        end else begin
            corr_vld <= win_vld && full_next;
            if (win_vld && fill_cnt != FILL_W'(LEN)) fill_cnt <= fill_cnt + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // delay line and registered sums
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (win_vld) begin
            dl_re <= nxt_re;
            dl_im <= nxt_im;
            if (full_next) begin
                corr_re <= sum_re;
                corr_im <= sum_im;
            end
        end
    end

endmodule

//--- ssync_corr/sample_window.sv
module sample_window #(
    parameter int FRAME_LEN = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  ssync_pkg::sample_t di_re,
    input  ssync_pkg::sample_t di_im,
    input  logic               di_vld,
    output ssync_pkg::sample_t do_re,
    output ssync_pkg::sample_t do_im,
    output logic               do_vld,
    output ssync_pkg::sample_t win_re,
    output ssync_pkg::sample_t win_im,
    output logic               win_vld
);

    localparam int CNT_W = $clog2(FRAME_LEN + 1);

    logic [CNT_W-1:0] acc_cnt;     // accepted samples, saturates at FRAME_LEN
    logic             in_frame;

    assign in_frame = (acc_cnt != CNT_W'(FRAME_LEN));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_cnt <= '0;
            do_vld  <= 1'b0;
            win_vld <= 1'b0;
        end else begin
            do_vld  <= di_vld;
            win_vld <= di_vld && in_frame;
            if (di_vld && in_frame) acc_cnt <= acc_cnt + 1'b1;
        end
    end

    // payload, same register stage as the valids
    always_ff @(posedge clk) begin
        do_re  <= di_re;
        do_im  <= di_im;
        win_re <= di_re;
        win_im <= di_im;
    end

endmodule

//--- common/ssync_pkg.sv
package ssync_pkg;

    //----------------------------------------------------------------------
    // input samples
    //----------------------------------------------------------------------
    localparam int SAMPLE_W = 12;                 // one real or imag part
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    //----------------------------------------------------------------------
    // local preamble
    //----------------------------------------------------------------------
    localparam int PREAMBLE_LEN = 16;

    // bit k set: tap k is +1, clear: -1
    // tap 0 lines up with the oldest sample of the window
    localparam logic [PREAMBLE_LEN-1:0] PREAMBLE_TAPS = 16'b1100_1010_0111_0001;

    //----------------------------------------------------------------------
    // correlation, energy and index
    //----------------------------------------------------------------------
    localparam int CORR_W = SAMPLE_W + 4;         // room for 16 taps
    typedef logic signed [CORR_W-1:0] corr_t;

    localparam int ENERGY_W = CORR_W + 1;         // |re| + |im|
    typedef logic [ENERGY_W-1:0] energy_t;

    localparam int IDX_W = 10;
    typedef logic [IDX_W-1:0] idx_t;

endpackage
